// ==== logic/mem_pkg.sv ====
package mem_pkg;

  // access size as carried on the request
  typedef enum logic [1:0] {
    SZ_BYTE  = 2'd0,
    SZ_HALF  = 2'd1,
    SZ_WORD  = 2'd2,
    SZ_DWORD = 2'd3
  } size_t;

  // data path width and byte lanes
  localparam int DATA_W = 64;
  localparam int STRB_W = DATA_W / 8;

  // byte offset inside one data word
  localparam int OFF_W = $clog2(STRB_W);

  // default geometry for the top level
  localparam int DEF_ADDR_W = 16;
  localparam int DEF_DEPTH  = 256;

endpackage

// ==== logic/store_align.sv ====
`timescale 1ns/1ps

module store_align (
  input  mem_pkg::size_t              size,
  input  logic [mem_pkg::OFF_W-1:0]   offset,
  input  logic [mem_pkg::DATA_W-1:0]  wdata,
  output logic [mem_pkg::STRB_W-1:0]  strb,
  output logic [mem_pkg::DATA_W-1:0]  wdata_aligned,
  output logic                        misaligned
);

  logic [mem_pkg::STRB_W-1:0] base_strb;

  // lanes covered by the access before shifting to the offset
  always_comb begin
    case (size)
      mem_pkg::SZ_BYTE:  base_strb = 8'b0000_0001;
      mem_pkg::SZ_HALF:  base_strb = 8'b0000_0011;
      mem_pkg::SZ_WORD:  base_strb = 8'b0000_1111;
      default:           base_strb = 8'b1111_1111;
    endcase
  end

  // offset must be a multiple of the access size
  always_comb begin
    case (size)
      mem_pkg::SZ_BYTE:  misaligned = 1'b0;
      mem_pkg::SZ_HALF:  misaligned = offset[0];
      mem_pkg::SZ_WORD:  misaligned = |offset[1:0];
      default:           misaligned = |offset;
    endcase
  end

  // misaligned accesses touch no lane at all
  assign strb = misaligned ? '0 : mem_pkg::STRB_W'(base_strb << offset);

  // store value sits in the low bytes, move it up to its lanes
  assign wdata_aligned = wdata << {offset, 3'b000};

endmodule

// ==== logic/load_extract.sv ====
`timescale 1ns/1ps

module load_extract (
  input  logic [mem_pkg::DATA_W-1:0]  rdata_raw,
  input  logic [mem_pkg::OFF_W-1:0]   offset,
  input  mem_pkg::size_t              size,
  input  logic                        unsigned_ld,
  output logic [mem_pkg::DATA_W-1:0]  rdata
);

  logic [mem_pkg::DATA_W-1:0] shifted;
  logic                       fill;

  // bring the addressed byte down to lane 0
  assign shifted = rdata_raw >> {offset, 3'b000};

  // top bit of the field, or zero for unsigned loads
  always_comb begin
    case (size)
      mem_pkg::SZ_BYTE:  fill = shifted[7] & ~unsigned_ld;
      mem_pkg::SZ_HALF:  fill = shifted[15] & ~unsigned_ld;
      mem_pkg::SZ_WORD:  fill = shifted[31] & ~unsigned_ld;
      default:           fill = 1'b0;
    endcase
  end

  always_comb begin
    case (size)
      mem_pkg::SZ_BYTE: begin
        rdata = {{56{fill}}, shifted[7:0]};
      end
      mem_pkg::SZ_HALF: begin
        rdata = {{48{fill}}, shifted[15:0]};
      end
      mem_pkg::SZ_WORD: begin
        rdata = {{32{fill}}, shifted[31:0]};
      end
      default: begin
        // full word needs no extension
        rdata = shifted;
      end
    endcase
  end

endmodule

// ==== logic/data_ram.sv ====
`timescale 1ns/1ps

module data_ram #(
  parameter int DEPTH = mem_pkg::DEF_DEPTH
) (
  input  logic                        clk,
  input  logic                        en,
  input  logic                        we,
  input  logic [$clog2(DEPTH)-1:0]    idx,
  input  logic [mem_pkg::STRB_W-1:0]  strb,
  input  logic [mem_pkg::DATA_W-1:0]  wdata,
  output logic [mem_pkg::DATA_W-1:0]  rdata
);

  logic [mem_pkg::DATA_W-1:0] mem [DEPTH];

  // byte lanes written independently under the strobe
  always_ff @(posedge clk) begin
    if (en && we) begin
      for (int i = 0; i < mem_pkg::STRB_W; i++) begin
        if (strb[i]) begin
          mem[idx][i*8 +: 8] <= wdata[i*8 +: 8];
        end
      end
    end
  end

  // read word is held until the next enabled read
  always_ff @(posedge clk) begin
    if (en && !we) begin
      rdata <= mem[idx];
    end
  end

  // controller only issues writes for legal, aligned requests
  a_write_has_lanes : assert property (
    @(posedge clk) (en && we) |-> (strb != '0)
  ) else $error("data_ram write with empty strobe");

endmodule

// ==== logic/mem_access_ctrl.sv ====
`timescale 1ns/1ps

module mem_access_ctrl #(
  parameter int ADDR_W = mem_pkg::DEF_ADDR_W,
  parameter int DEPTH  = mem_pkg::DEF_DEPTH
) (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        req,
  input  logic                        we,
  input  mem_pkg::size_t              size,
  input  logic                        unsigned_ld,
  input  logic [ADDR_W-1:0]           addr,
  input  logic [mem_pkg::DATA_W-1:0]  wdata,
  output logic                        ack,
  output logic [mem_pkg::DATA_W-1:0]  rdata,
  output logic                        err,
  output logic                        ram_en,
  output logic                        ram_we,
  output logic [$clog2(DEPTH)-1:0]    ram_idx,
  output logic [mem_pkg::STRB_W-1:0]  ram_strb,
  output logic [mem_pkg::DATA_W-1:0]  ram_wdata,
  input  logic [mem_pkg::DATA_W-1:0]  ram_rdata,
  output logic [mem_pkg::OFF_W-1:0]   cap_offset,
  output mem_pkg::size_t              cap_size,
  output logic                        cap_unsigned,
  output logic [mem_pkg::DATA_W-1:0]  cap_wdata,
  input  logic [mem_pkg::STRB_W-1:0]  strb,
  input  logic [mem_pkg::DATA_W-1:0]  wdata_aligned,
  input  logic                        misaligned,
  input  logic [mem_pkg::DATA_W-1:0]  ld_data
);

  localparam int IDX_W = $clog2(DEPTH);

  typedef enum logic [1:0] {ST_IDLE, ST_ACCESS, ST_RESULT, ST_DONE} state_t;

  state_t            state;
  logic              cap_we;
  logic [ADDR_W-1:0] cap_addr;
  logic              out_of_range;
  logic              bad;

  // request fields latched as the access starts
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && req) begin
      cap_we       <= we;
      cap_size     <= size;
      cap_unsigned <= unsigned_ld;
      cap_addr     <= addr;
      cap_wdata    <= wdata;
    end
  end

  assign cap_offset = cap_addr[mem_pkg::OFF_W-1:0];

  // any address bit above the word index is outside the RAM
  assign out_of_range = (cap_addr >> (mem_pkg::OFF_W + IDX_W)) != '0;
  assign bad          = out_of_range | misaligned;

  // single RAM cycle that illegal requests skip
  assign ram_en    = (state == ST_ACCESS) && !bad;
  assign ram_we    = cap_we;
  assign ram_idx   = cap_addr[mem_pkg::OFF_W +: IDX_W];
  assign ram_strb  = strb;
  assign ram_wdata = wdata_aligned;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= ST_IDLE;
      ack   <= 1'b0;
      err   <= 1'b0;
      rdata <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req) state <= ST_ACCESS;
        end
        ST_ACCESS: begin
          state <= ST_RESULT;
        end
        ST_RESULT: begin
          // stores and failed accesses return zero
          ack   <= 1'b1;
          err   <= bad;
          rdata <= (bad || cap_we) ? '0 : ld_data;
          state <= ST_DONE;
        end
        default: begin
          // hold the result until the requester lets go
          if (!req) begin
            ack   <= 1'b0;
            state <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // ack only answers a request that is still up
  a_no_ack_without_req : assert property (
    @(posedge clk) disable iff (!arst_n) (!req && !ack) |=> !ack
  ) else $error("ack raised with req low");

  a_result_stable : assert property (
    @(posedge clk) disable iff (!arst_n) (ack && req) |=> ($stable(rdata) && $stable(err))
  ) else $error("result changed while ack and req high");

endmodule

// ==== logic/mem_top.sv ====
`timescale 1ns/1ps

module mem_top #(
  parameter int ADDR_W = mem_pkg::DEF_ADDR_W,
  parameter int DEPTH  = mem_pkg::DEF_DEPTH
) (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        req,
  input  logic                        we,
  input  mem_pkg::size_t              size,
  input  logic                        unsigned_ld,
  input  logic [ADDR_W-1:0]           addr,
  input  logic [mem_pkg::DATA_W-1:0]  wdata,
  output logic                        ack,
  output logic [mem_pkg::DATA_W-1:0]  rdata,
  output logic                        err
);

  localparam int IDX_W = $clog2(DEPTH);

  // controller to RAM
  logic                       ram_en;
  logic                       ram_we;
  logic [IDX_W-1:0]           ram_idx;
  logic [mem_pkg::STRB_W-1:0] ram_strb;
  logic [mem_pkg::DATA_W-1:0] ram_wdata;
  logic [mem_pkg::DATA_W-1:0] ram_rdata;

  // captured request fields for the lane logic
  logic [mem_pkg::OFF_W-1:0]  cap_offset;
  mem_pkg::size_t             cap_size;
  logic                       cap_unsigned;
  logic [mem_pkg::DATA_W-1:0] cap_wdata;

  logic [mem_pkg::STRB_W-1:0] strb;
  logic [mem_pkg::DATA_W-1:0] wdata_aligned;
  logic                       misaligned;
  logic [mem_pkg::DATA_W-1:0] ld_data;

  mem_access_ctrl #(
    .ADDR_W (ADDR_W),
    .DEPTH  (DEPTH)
  ) ctrl_i (
    .clk, .arst_n, .req, .we, .size, .unsigned_ld, .addr, .wdata,
    .ack, .rdata, .err,
    .ram_en, .ram_we, .ram_idx, .ram_strb, .ram_wdata, .ram_rdata,
    .cap_offset, .cap_size, .cap_unsigned, .cap_wdata,
    .strb, .wdata_aligned, .misaligned, .ld_data
  );

  store_align align_i (
    .size          (cap_size),
    .offset        (cap_offset),
    .wdata         (cap_wdata),
    .strb          (strb),
    .wdata_aligned (wdata_aligned),
    .misaligned    (misaligned)
  );

  data_ram #(
    .DEPTH (DEPTH)
  ) ram_i (
    .clk   (clk),
    .en    (ram_en),
    .we    (ram_we),
    .idx   (ram_idx),
    .strb  (ram_strb),
    .wdata (ram_wdata),
    .rdata (ram_rdata)
  );

  load_extract extract_i (
    .rdata_raw   (ram_rdata),
    .offset      (cap_offset),
    .size        (cap_size),
    .unsigned_ld (cap_unsigned),
    .rdata       (ld_data)
  );

endmodule

// ==== tb/mem_tb.sv ====
`timescale 1ns/1ps

module mem_tb;

  localparam int ADDR_W       = mem_pkg::DEF_ADDR_W;
  localparam int DEPTH        = mem_pkg::DEF_DEPTH;
  localparam int NUM_BYTES    = DEPTH * mem_pkg::STRB_W;
  localparam int RANGE_BITS   = $clog2(NUM_BYTES);
  localparam int HIGH_MAX     = (1 << (ADDR_W - RANGE_BITS)) - 1;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_TXN      = 400;
  // clear pass and random phase take at most 9 cycles per access plus margin
  localparam int TIMEOUT_CYCLES = 8000;

  logic                       clk;
  logic                       arst_n;
  logic                       req;
  logic                       we;
  mem_pkg::size_t             size;
  logic                       unsigned_ld;
  logic [ADDR_W-1:0]          addr;
  logic [mem_pkg::DATA_W-1:0] wdata;
  logic                       ack;
  logic [mem_pkg::DATA_W-1:0] rdata;
  logic                       err;

  // byte-wide reference memory
  logic [7:0]  model_mem [NUM_BYTES];
  int unsigned cycles = 0;
  int unsigned txn_count;

  mem_top dut_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .req         (req),
    .we          (we),
    .size        (size),
    .unsigned_ld (unsigned_ld),
    .addr        (addr),
    .wdata       (wdata),
    .ack         (ack),
    .rdata       (rdata),
    .err         (err)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("Timeout: the run went past %0d clock cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $fatal(1, "timeout");
    end
  end

  task automatic check_data(input logic [mem_pkg::DATA_W-1:0] got,
                            input logic [mem_pkg::DATA_W-1:0] exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("Simulation failed");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_err(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
      $display("Simulation failed");
      $fatal(1, "flag mismatch");
    end
  endtask

  task automatic report_failure(input string msg);
    $display("Error at %0t: %s", $time, msg);
    $display("Simulation failed");
    $fatal(1, "handshake error");
  endtask

  function automatic int size_bytes(input mem_pkg::size_t s);
    return 1 << s;
  endfunction

  // aligned to its own size and inside the RAM
  function automatic logic access_legal(input logic [ADDR_W-1:0] a, input mem_pkg::size_t s);
    int n;
    n = size_bytes(s);
    return (int'(a) % n == 0) && (int'(a) < NUM_BYTES);
  endfunction

  function automatic logic [mem_pkg::DATA_W-1:0] expected_load(input int base,
      input mem_pkg::size_t s, input logic uns);
    logic [mem_pkg::DATA_W-1:0] v;
    int                         n;
    logic                       top;
    v = '0;
    n = size_bytes(s);
    for (int i = 0; i < n; i++) begin
      v[i*8 +: 8] = model_mem[base + i];
    end
    top = v[n*8-1] & ~uns;
    for (int i = n * 8; i < mem_pkg::DATA_W; i++) begin
      v[i] = top;
    end
    return v;
  endfunction

  // little endian store of the low bytes
  task automatic apply_store(input int base, input mem_pkg::size_t s,
                             input logic [mem_pkg::DATA_W-1:0] d);
    for (int i = 0; i < size_bytes(s); i++) begin
      model_mem[base + i] = d[i*8 +: 8];
    end
  endtask

  // one four-phase handshake entered and left just after a falling edge
  task automatic do_access(input logic wr, input mem_pkg::size_t s, input logic uns,
      input logic [ADDR_W-1:0] a, input logic [mem_pkg::DATA_W-1:0] d, input int hold,
      output logic [mem_pkg::DATA_W-1:0] got_data, output logic got_err);
    req         = 1'b1;
    we          = wr;
    size        = s;
    unsigned_ld = uns;
    addr        = a;
    wdata       = d;
    for (int k = 1; k <= 3; k++) begin
      @(negedge clk);
      if (k < 3 && ack) report_failure("ack rose before the third edge after req");
    end
    if (!ack) report_failure("ack did not rise on the third edge after req");
    got_data = rdata;
    got_err  = err;
    for (int k = 0; k < hold; k++) begin
      @(negedge clk);
      if (!ack) report_failure("ack dropped while req was still held");
      check_data(rdata, got_data, "rdata during held req");
      check_err(err, got_err, "err during held req");
    end
    // request fields are free to change once req is low
    req   = 1'b0;
    we    = 1'($urandom_range(1, 0));
    addr  = ADDR_W'($urandom);
    wdata = {$urandom, $urandom};
    @(negedge clk);
    if (ack) report_failure("ack still high one edge after req dropped");
  endtask

  task automatic run_checked(input logic wr, input mem_pkg::size_t s, input logic uns,
      input logic [ADDR_W-1:0] a, input logic [mem_pkg::DATA_W-1:0] d);
    logic [mem_pkg::DATA_W-1:0] exp_data;
    logic                       exp_err;
    logic [mem_pkg::DATA_W-1:0] got_data;
    logic                       got_err;
    int                         hold;
    exp_err  = !access_legal(a, s);
    exp_data = '0;
    if (!exp_err && !wr) begin
      exp_data = expected_load(int'(a), s, uns);
    end
    hold = int'($urandom_range(5, 0));
    do_access(wr, s, uns, a, d, hold, got_data, got_err);
    check_err(got_err, exp_err, "err");
    check_data(got_data, exp_data, "rdata");
    if (!exp_err && wr) begin
      apply_store(int'(a), s, d);
    end
    txn_count++;
  endtask

  task automatic random_access();
    logic                       wr;
    mem_pkg::size_t             s;
    logic                       uns;
    logic [ADDR_W-1:0]          a;
    logic [mem_pkg::DATA_W-1:0] d;
    int                         kind;
    int                         n;
    int                         word;
    int                         off;
    wr   = 1'($urandom_range(1, 0));
    s    = mem_pkg::size_t'(2'($urandom_range(3, 0)));
    uns  = 1'($urandom_range(1, 0));
    d    = {$urandom, $urandom};
    kind = int'($urandom_range(9, 0));
    // kind 0 misaligned, kind 1 out of range, rest legal
    if (kind == 0 && s == mem_pkg::SZ_BYTE) s = mem_pkg::SZ_HALF;
    n = size_bytes(s);
    // mostly a small window so loads hit earlier stores
    if ($urandom_range(3, 0) == 0) begin
      word = int'($urandom_range(DEPTH - 1, 0));
    end else begin
      word = int'($urandom_range(15, 0));
    end
    off = int'($urandom_range(7, 0)) / n * n;
    if (kind == 0) off = off + 1;
    a = ADDR_W'(word * 8 + off);
    if (kind == 1) begin
      a = a | ADDR_W'(int'($urandom_range(HIGH_MAX, 1)) << RANGE_BITS);
    end
    run_checked(wr, s, uns, a, d);
    if (kind <= 1 && wr) begin
      // rejected store must leave the word alone
      run_checked(1'b0, mem_pkg::SZ_DWORD, 1'b0, ADDR_W'(word * 8), '0);
    end else if (!wr && s != mem_pkg::SZ_DWORD) begin
      // same field with the other extension
      run_checked(1'b0, s, ~uns, a, '0);
    end
  endtask

  initial begin
    arst_n      = 1'b0;
    req         = 1'b0;
    we          = 1'b0;
    size        = mem_pkg::SZ_BYTE;
    unsigned_ld = 1'b0;
    addr        = '0;
    wdata       = '0;
    void'($urandom(14));
    txn_count   = 0;
    for (int i = 0; i < NUM_BYTES; i++) begin
      model_mem[i] = 8'h00;
    end
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      check_err(ack, 1'b0, "ack in reset");
      check_err(err, 1'b0, "err in reset");
    end
    arst_n = 1'b1;
    repeat (2) begin
      @(negedge clk);
      check_err(ack, 1'b0, "ack after reset");
      check_err(err, 1'b0, "err after reset");
      check_data(rdata, '0, "rdata after reset");
    end
    // zero every word so the model and the RAM agree
    for (int w = 0; w < DEPTH; w++) begin
      run_checked(1'b1, mem_pkg::SZ_DWORD, 1'b0, ADDR_W'(w * 8), '0);
    end
    txn_count = 0;
    while (txn_count < NUM_TXN) begin
      random_access();
    end
    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== sim.f ====
logic/mem_pkg.sv
logic/store_align.sv
logic/load_extract.sv
logic/data_ram.sv
logic/mem_access_ctrl.sv
logic/mem_top.sv
tb/mem_tb.sv

// ==== Makefile ====
TOP := mem_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o $(TOP)_sim
	./obj_dir/$(TOP)_sim

lint:
	verilator --lint-only --timing -Wall -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir
